// ==== common/farm_geometry_pkg.sv ====
package farm_geometry_pkg;

	// 160x120 grid, the marker never leaves the inner bounds
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// area under the player marker
	typedef enum logic [2:0]
	{
		ZONE_NONE   = 3'd0,
		ZONE_FIELD  = 3'd1,
		ZONE_MILL   = 3'd2,
		ZONE_OVEN   = 3'd3,
		ZONE_MARKET = 3'd4
	} zone_t;

	localparam coord_x_t START_X = 8'd50;
	localparam coord_y_t START_Y = 7'd50;

	localparam coord_x_t MIN_X = 8'd12;
	localparam coord_x_t MAX_X = 8'd133;
	localparam coord_y_t MIN_Y = 7'd12;
	localparam coord_y_t MAX_Y = 7'd72;

	// zone edges, all exclusive
	localparam coord_y_t FIELD_Y_LO  = 7'd11;
	localparam coord_y_t FIELD_Y_HI  = 7'd14;
	localparam coord_x_t FIELD_X_LO  = 8'd21;
	localparam coord_x_t FIELD_X_HI  = 8'd119;
	localparam coord_y_t MILL_Y_LO   = 7'd35;
	localparam coord_y_t MILL_Y_HI   = 7'd108;
	localparam coord_x_t MILL_X_HI   = 8'd18;
	localparam coord_y_t OVEN_Y_LO   = 7'd68;
	localparam coord_y_t OVEN_Y_HI   = 7'd108;
	localparam coord_x_t OVEN_X_LO   = 8'd41;
	localparam coord_x_t OVEN_X_HI   = 8'd94;
	localparam coord_y_t MARKET_Y_LO = 7'd68;
	localparam coord_y_t MARKET_Y_HI = 7'd108;
	localparam coord_x_t MARKET_X_LO = 8'd131;
	localparam coord_x_t MARKET_X_HI = 8'd148;

endpackage

// ==== common/farm_rules_pkg.sv ====
package farm_rules_pkg;

	// number of loaves sold, wraps at 256
	typedef logic [7:0] score_t;

	// one seven-segment digit, active low, bit 0 is segment a
	typedef logic [6:0] segments_t;

	// rich once more than this many loaves are sold
	localparam score_t RICH_THRESHOLD = 8'd3;

	// board timing at 50 MHz
	localparam int DEFAULT_STEP_CYCLES = 703520;

	// field lifetime
	localparam int DEFAULT_GROW_CYCLES = 268435455;
	localparam int DEFAULT_WITHER_CYCLES = 536870910;

	// station delays
	localparam int DEFAULT_REFINE_CYCLES = 268435455;
	localparam int DEFAULT_BAKE_CYCLES = 268435455;

endpackage

// ==== farm_game_top.f ====
common/farm_geometry_pkg.sv
common/farm_rules_pkg.sv
logic/player_motion.sv
field/crop_field.sv
stations/process_station.sv
logic/inventory_tracker.sv
logic/score_display.sv
logic/farm_game_top.sv
test/farm_game_tb.sv

// ==== field/crop_field.sv ====
`timescale 1ns/1ps

module crop_field
#(
	parameter int GROW_CYCLES   = farm_rules_pkg::DEFAULT_GROW_CYCLES,
	parameter int WITHER_CYCLES = farm_rules_pkg::DEFAULT_WITHER_CYCLES
)
(
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     act_strobe,
	input  farm_geometry_pkg::zone_t zone,
	output logic                     crop_ripe,
	output logic                     crop_withered,
	output logic                     harvest
);

	import farm_geometry_pkg::*;

	localparam int CNT_MAX = (GROW_CYCLES > WITHER_CYCLES) ? GROW_CYCLES : WITHER_CYCLES;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [1:0]
	{
		FIELD_GROWING,
		FIELD_RIPE,
		FIELD_WITHERED
	} field_state_t;

	field_state_t     state;
	logic [CNT_W-1:0] life_cnt;
	logic             field_act;

	assign field_act = act_strobe && (zone == ZONE_FIELD);

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state    <= FIELD_GROWING;
			life_cnt <= '0;
			harvest  <= 1'b0;
		end
		else
		begin
			harvest <= 1'b0;
			case (state)
				FIELD_GROWING:
				begin
					if (life_cnt == CNT_W'(GROW_CYCLES))
					begin
						state    <= FIELD_RIPE;
						life_cnt <= '0;
					end
					else
					begin
						life_cnt <= life_cnt + 1'b1;
					end
				end
				FIELD_RIPE:
				begin
					// picking beats withering on the same cycle
					if (field_act)
					begin
						harvest  <= 1'b1;
						state    <= FIELD_GROWING;
						life_cnt <= '0;
					end
					else if (life_cnt == CNT_W'(WITHER_CYCLES))
					begin
						state <= FIELD_WITHERED;
					end
					else
					begin
						life_cnt <= life_cnt + 1'b1;
					end
				end
				FIELD_WITHERED:
				begin
					// replant, nothing to carry away
					if (field_act)
					begin
						state    <= FIELD_GROWING;
						life_cnt <= '0;
					end
				end
				default:
				begin
					state    <= FIELD_GROWING;
					life_cnt <= '0;
				end
			endcase
		end
	end

	assign crop_ripe     = (state == FIELD_RIPE);
	assign crop_withered = (state == FIELD_WITHERED);

endmodule

// ==== logic/farm_game_top.sv ====
`timescale 1ns/1ps

module farm_game_top
#(
	parameter int STEP_CYCLES   = farm_rules_pkg::DEFAULT_STEP_CYCLES,
	parameter int GROW_CYCLES   = farm_rules_pkg::DEFAULT_GROW_CYCLES,
	parameter int WITHER_CYCLES = farm_rules_pkg::DEFAULT_WITHER_CYCLES,
	parameter int REFINE_CYCLES = farm_rules_pkg::DEFAULT_REFINE_CYCLES,
	parameter int BAKE_CYCLES   = farm_rules_pkg::DEFAULT_BAKE_CYCLES
)
(
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        move_up,
	input  logic                        move_down,
	input  logic                        move_left,
	input  logic                        move_right,
	input  logic                        act,
	input  logic                        clear_items,
	output farm_geometry_pkg::coord_x_t pos_x,
	output farm_geometry_pkg::coord_y_t pos_y,
	output logic                        crop_ripe,
	output logic                        crop_withered,
	output logic                        flour_ready,
	output logic                        bread_ready,
	output logic                        has_wheat,
	output logic                        has_flour,
	output logic                        has_bread,
	output farm_rules_pkg::score_t      score,
	output logic                        rich,
	output farm_rules_pkg::segments_t   hex0,
	output farm_rules_pkg::segments_t   hex1
);

	import farm_geometry_pkg::*;

	zone_t zone;
	logic  act_strobe;
	logic  clear_strobe;
	logic  harvest;
	logic  wheat_taken;
	logic  flour_made;
	logic  flour_taken;
	logic  bread_made;

	player_motion #(.STEP_CYCLES(STEP_CYCLES)) i_motion (
		.clk          (clk),
		.resetn       (resetn),
		.move_up      (move_up),
		.move_down    (move_down),
		.move_left    (move_left),
		.move_right   (move_right),
		.act          (act),
		.clear_items  (clear_items),
		.pos_x        (pos_x),
		.pos_y        (pos_y),
		.zone         (zone),
		.act_strobe   (act_strobe),
		.clear_strobe (clear_strobe)
	);

	crop_field #(.GROW_CYCLES(GROW_CYCLES), .WITHER_CYCLES(WITHER_CYCLES)) i_field (
		.clk           (clk),
		.resetn        (resetn),
		.act_strobe    (act_strobe),
		.zone          (zone),
		.crop_ripe     (crop_ripe),
		.crop_withered (crop_withered),
		.harvest       (harvest)
	);

	// wheat in, flour out
	process_station #(.STATION_ZONE(ZONE_MILL), .PROCESS_CYCLES(REFINE_CYCLES)) i_mill (
		.clk          (clk),
		.resetn       (resetn),
		.act_strobe   (act_strobe),
		.zone         (zone),
		.has_input    (has_wheat),
		.take_item    (wheat_taken),
		.deliver_item (flour_made),
		.item_ready   (flour_ready)
	);

	// flour in, bread out
	process_station #(.STATION_ZONE(ZONE_OVEN), .PROCESS_CYCLES(BAKE_CYCLES)) i_oven (
		.clk          (clk),
		.resetn       (resetn),
		.act_strobe   (act_strobe),
		.zone         (zone),
		.has_input    (has_flour),
		.take_item    (flour_taken),
		.deliver_item (bread_made),
		.item_ready   (bread_ready)
	);

	inventory_tracker i_inventory (
		.clk          (clk),
		.resetn       (resetn),
		.act_strobe   (act_strobe),
		.clear_strobe (clear_strobe),
		.zone         (zone),
		.harvest      (harvest),
		.wheat_taken  (wheat_taken),
		.flour_made   (flour_made),
		.flour_taken  (flour_taken),
		.bread_made   (bread_made),
		.has_wheat    (has_wheat),
		.has_flour    (has_flour),
		.has_bread    (has_bread),
		.score        (score),
		.rich         (rich)
	);

	score_display i_display (
		.score (score),
		.hex0  (hex0),
		.hex1  (hex1)
	);

endmodule

// ==== logic/inventory_tracker.sv ====
`timescale 1ns/1ps

module inventory_tracker
(
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     act_strobe,
	input  logic                     clear_strobe,
	input  farm_geometry_pkg::zone_t zone,
	input  logic                     harvest,
	input  logic                     wheat_taken,
	input  logic                     flour_made,
	input  logic                     flour_taken,
	input  logic                     bread_made,
	output logic                     has_wheat,
	output logic                     has_flour,
	output logic                     has_bread,
	output farm_rules_pkg::score_t   score,
	output logic                     rich
);

	import farm_geometry_pkg::*;
	import farm_rules_pkg::*;

	logic   sell;
	score_t score_next;

	assign sell       = act_strobe && (zone == ZONE_MARKET) && has_bread;
	assign score_next = score + 8'd1;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			has_wheat <= 1'b0;
			has_flour <= 1'b0;
			has_bread <= 1'b0;
			score     <= '0;
			rich      <= 1'b0;
		end
		else
		begin
			// wheat from the field, gone into the mill
			if (harvest)
				has_wheat <= 1'b1;
			if (wheat_taken)
				has_wheat <= 1'b0;

			if (flour_made)
				has_flour <= 1'b1;
			if (flour_taken)
				has_flour <= 1'b0;

			if (bread_made)
				has_bread <= 1'b1;

			if (sell)
			begin
				has_bread <= 1'b0;
				score     <= score_next;
				rich      <= (score_next > RICH_THRESHOLD);
			end

			// dropping everything wins, the score is kept
			if (clear_strobe)
			begin
				has_wheat <= 1'b0;
				has_flour <= 1'b0;
				has_bread <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/player_motion.sv ====
`timescale 1ns/1ps

module player_motion
#(
	parameter int STEP_CYCLES = farm_rules_pkg::DEFAULT_STEP_CYCLES
)
(
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        move_up,
	input  logic                        move_down,
	input  logic                        move_left,
	input  logic                        move_right,
	input  logic                        act,
	input  logic                        clear_items,
	output farm_geometry_pkg::coord_x_t pos_x,
	output farm_geometry_pkg::coord_y_t pos_y,
	output farm_geometry_pkg::zone_t    zone,
	output logic                        act_strobe,
	output logic                        clear_strobe
);

	import farm_geometry_pkg::*;

	localparam int STEP_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

	logic [STEP_W-1:0] step_cnt;
	logic              step_tick;

	// rate divider for the step tick
	assign step_tick = (step_cnt == STEP_W'(STEP_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			step_cnt <= '0;
		end
		else if (step_tick)
		begin
			step_cnt <= '0;
		end
		else
		begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	// first high input wins, a blocked move eats the tick
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pos_x        <= START_X;
			pos_y        <= START_Y;
			act_strobe   <= 1'b0;
			clear_strobe <= 1'b0;
		end
		else
		begin
			act_strobe   <= 1'b0;
			clear_strobe <= 1'b0;
			if (step_tick)
			begin
				if (move_up)
				begin
					if (pos_y > MIN_Y)
						pos_y <= pos_y - 7'd1;
				end
				else if (move_down)
				begin
					if (pos_y < MAX_Y)
						pos_y <= pos_y + 7'd1;
				end
				else if (move_left)
				begin
					if (pos_x > MIN_X)
						pos_x <= pos_x - 8'd1;
				end
				else if (move_right)
				begin
					if (pos_x < MAX_X)
						pos_x <= pos_x + 8'd1;
				end
				else if (act)
				begin
					act_strobe <= 1'b1;
				end
				else if (clear_items)
				begin
					clear_strobe <= 1'b1;
				end
			end
		end
	end

	// zones are disjoint so order does not matter
	always_comb
	begin
		zone = ZONE_NONE;
		if ((pos_y > FIELD_Y_LO) && (pos_y < FIELD_Y_HI) &&
			(pos_x > FIELD_X_LO) && (pos_x < FIELD_X_HI))
			zone = ZONE_FIELD;
		else if ((pos_y > MILL_Y_LO) && (pos_y < MILL_Y_HI) && (pos_x < MILL_X_HI))
			zone = ZONE_MILL;
		else if ((pos_y > OVEN_Y_LO) && (pos_y < OVEN_Y_HI) &&
			(pos_x > OVEN_X_LO) && (pos_x < OVEN_X_HI))
			zone = ZONE_OVEN;
		else if ((pos_y > MARKET_Y_LO) && (pos_y < MARKET_Y_HI) &&
			(pos_x > MARKET_X_LO) && (pos_x < MARKET_X_HI))
			zone = ZONE_MARKET;
	end

endmodule

// ==== logic/score_display.sv ====
`timescale 1ns/1ps

module score_display
(
	input  farm_rules_pkg::score_t    score,
	output farm_rules_pkg::segments_t hex0,
	output farm_rules_pkg::segments_t hex1
);

	import farm_rules_pkg::*;

	// active low, bit 0 is segment a
	function automatic segments_t nibble_to_segments(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110;
		endcase
	endfunction

	assign hex0 = nibble_to_segments(score[3:0]);
	assign hex1 = nibble_to_segments(score[7:4]);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module farm_game_tb \
	-f farm_game_top.f -o farm_game_sim > build.log 2>&1 \
	|| { echo "compile failed, see build.log"; exit 1; }

./obj_dir/farm_game_sim > sim.log 2>&1

grep -q "Regression failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== stations/process_station.sv ====
`timescale 1ns/1ps

module process_station
#(
	parameter farm_geometry_pkg::zone_t STATION_ZONE = farm_geometry_pkg::ZONE_MILL,
	parameter int PROCESS_CYCLES = farm_rules_pkg::DEFAULT_REFINE_CYCLES
)
(
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     act_strobe,
	input  farm_geometry_pkg::zone_t zone,
	input  logic                     has_input,
	output logic                     take_item,
	output logic                     deliver_item,
	output logic                     item_ready
);

	import farm_geometry_pkg::*;

	localparam int CNT_W = $clog2(PROCESS_CYCLES + 1);

	typedef enum logic [1:0]
	{
		STATION_IDLE,
		STATION_BUSY,
		STATION_READY
	} station_state_t;

	station_state_t   state;
	logic [CNT_W-1:0] work_cnt;
	logic             station_act;

	assign station_act = act_strobe && (zone == STATION_ZONE);

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state        <= STATION_IDLE;
			work_cnt     <= '0;
			take_item    <= 1'b0;
			deliver_item <= 1'b0;
		end
		else
		begin
			take_item    <= 1'b0;
			deliver_item <= 1'b0;
			case (state)
				STATION_IDLE:
				begin
					if (station_act && has_input)
					begin
						take_item <= 1'b1;
						// ready shows exactly PROCESS_CYCLES after take_item
						work_cnt  <= CNT_W'(PROCESS_CYCLES - 1);
						state     <= STATION_BUSY;
					end
				end
				STATION_BUSY:
				begin
					if (work_cnt == '0)
						state <= STATION_READY;
					else
						work_cnt <= work_cnt - 1'b1;
				end
				STATION_READY:
				begin
					if (station_act)
					begin
						deliver_item <= 1'b1;
						state        <= STATION_IDLE;
					end
				end
				default:
				begin
					state <= STATION_IDLE;
				end
			endcase
		end
	end

	assign item_ready = (state == STATION_READY);

endmodule

// ==== test/farm_game_tb.sv ====
`timescale 1ns/1ps

module farm_game_tb;

	logic       clk;
	logic       resetn;
	logic       move_up;
	logic       move_down;
	logic       move_left;
	logic       move_right;
	logic       act;
	logic       clear_items;
	logic [7:0] pos_x;
	logic [6:0] pos_y;
	logic       crop_ripe;
	logic       crop_withered;
	logic       flour_ready;
	logic       bread_ready;
	logic       has_wheat;
	logic       has_flour;
	logic       has_bread;
	logic [7:0] score;
	logic       rich;
	logic [6:0] hex0;
	logic [6:0] hex1;

	farm_game_top #(
		.STEP_CYCLES   (4),
		.GROW_CYCLES   (40),
		.WITHER_CYCLES (60),
		.REFINE_CYCLES (20),
		.BAKE_CYCLES   (24)
	) i_dut (
		.clk (clk), .resetn (resetn),
		.move_up (move_up), .move_down (move_down),
		.move_left (move_left), .move_right (move_right),
		.act (act), .clear_items (clear_items),
		.pos_x (pos_x), .pos_y (pos_y),
		.crop_ripe (crop_ripe), .crop_withered (crop_withered),
		.flour_ready (flour_ready), .bread_ready (bread_ready),
		.has_wheat (has_wheat), .has_flour (has_flour), .has_bread (has_bread),
		.score (score), .rich (rich), .hex0 (hex0), .hex1 (hex1)
	);

	always #20 clk = ~clk;

	// standard 0 to F digits, active low, bit 0 is segment a
	function automatic logic [6:0] expected_segments(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0011000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	function automatic int distance(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	position_bounds: assert property (@(posedge clk) disable iff (!resetn)
		pos_x >= 8'd12 && pos_x <= 8'd133 && pos_y >= 7'd12 && pos_y <= 7'd72)
		else stop_with_failure("position left the movement bounds");

	single_step: assert property (@(posedge clk) disable iff (!resetn)
		distance(int'(pos_x), int'($past(pos_x))) + distance(int'(pos_y), int'($past(pos_y))) <= 1)
		else stop_with_failure("position moved more than one pixel in a step");

	// a step tick comes every fourth cycle
	step_spacing: assert property (@(posedge clk) disable iff (!resetn)
		$changed({pos_x, pos_y}) |-> $past({pos_x, pos_y}, 1) == $past({pos_x, pos_y}, 4))
		else stop_with_failure("position moved again before the next step tick");

	wheat_from_field: assert property (@(posedge clk) disable iff (!resetn)
		$rose(has_wheat) |-> $past(crop_ripe, 2))
		else stop_with_failure("has_wheat rose without a ripe crop being harvested");

	flour_from_mill: assert property (@(posedge clk) disable iff (!resetn)
		$rose(has_flour) |-> $past(flour_ready, 2))
		else stop_with_failure("has_flour rose without the mill being ready");

	bread_from_oven: assert property (@(posedge clk) disable iff (!resetn)
		$rose(has_bread) |-> $past(bread_ready, 2))
		else stop_with_failure("has_bread rose without the oven being ready");

	score_on_sale: assert property (@(posedge clk) disable iff (!resetn)
		$changed(score) |-> ($fell(has_bread) && score == $past(score) + 8'd1))
		else stop_with_failure("score changed without a bread sale");

	segment_decode: assert property (@(posedge clk) disable iff (!resetn)
		hex0 == expected_segments(score[3:0]) && hex1 == expected_segments(score[7:4]))
		else stop_with_failure($sformatf("ERROR hex0/hex1 got %h/%h for score %h",
			hex0, hex1, score));

	task automatic wait_for(input string what, ref logic sig, input int limit);
		int n;
		for (n = 0; n < limit && sig !== 1'b1; n++)
			@(negedge clk);
		if (sig !== 1'b1)
			stop_with_failure($sformatf("timeout waiting for %s", what));
	endtask

	task automatic go_x(input int target);
		int n;
		int limit;
		limit = distance(int'(pos_x), target) * 4 + 20;
		@(posedge clk);
		move_left  <= (target < int'(pos_x));
		move_right <= (target > int'(pos_x));
		for (n = 0; n < limit && int'(pos_x) != target; n++)
			@(negedge clk);
		if (int'(pos_x) != target)
			stop_with_failure($sformatf("timeout moving to x %0d", target));
		@(posedge clk);
		move_left  <= 1'b0;
		move_right <= 1'b0;
	endtask

	task automatic go_y(input int target);
		int n;
		int limit;
		limit = distance(int'(pos_y), target) * 4 + 20;
		@(posedge clk);
		move_up   <= (target < int'(pos_y));
		move_down <= (target > int'(pos_y));
		for (n = 0; n < limit && int'(pos_y) != target; n++)
			@(negedge clk);
		if (int'(pos_y) != target)
			stop_with_failure($sformatf("timeout moving to y %0d", target));
		@(posedge clk);
		move_up   <= 1'b0;
		move_down <= 1'b0;
	endtask

	// one action per call, then the inventory has settled
	task automatic do_action();
		@(posedge clk);
		act <= 1'b1;
		wait_for("act_strobe", i_dut.act_strobe, 20);
		@(posedge clk);
		act <= 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic harvest_wheat();
		int tries;
		for (tries = 0; tries < 4 && !has_wheat; tries++)
		begin
			// a withered field is replanted before it can ripen again
			if (crop_withered)
				do_action();
			wait_for("crop_ripe", crop_ripe, 200);
			do_action();
		end
		check_value("has_wheat", 32'(has_wheat), 32'h1);
	endtask

	task automatic make_and_sell(input int expected_score);
		go_x(50);
		go_y(12);
		harvest_wheat();
		go_x(15);
		go_y(40);
		do_action();
		check_value("has_wheat", 32'(has_wheat), 32'h0);
		wait_for("flour_ready", flour_ready, 60);
		do_action();
		check_value("has_flour", 32'(has_flour), 32'h1);
		go_x(50);
		go_y(70);
		do_action();
		check_value("has_flour", 32'(has_flour), 32'h0);
		wait_for("bread_ready", bread_ready, 60);
		do_action();
		check_value("has_bread", 32'(has_bread), 32'h1);
		go_x(132);
		do_action();
		check_value("has_bread", 32'(has_bread), 32'h0);
		check_value("score", 32'(score), 32'(expected_score));
		check_value("rich", 32'(rich), 32'(expected_score > 3));
	endtask

	initial
	begin
		int k;
		clk = 1'b0;
		resetn = 1'b0;
		move_up = 1'b0;
		move_down = 1'b0;
		move_left = 1'b0;
		move_right = 1'b0;
		act = 1'b0;
		clear_items = 1'b0;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_value("pos_x", 32'(pos_x), 32'd50);
		check_value("pos_y", 32'(pos_y), 32'd50);
		check_value("flags", 32'({crop_ripe, crop_withered, flour_ready, bread_ready,
			has_wheat, has_flour, has_bread, rich}), 32'h0);
		check_value("score", 32'(score), 32'h0);
		check_value("hex0", 32'(hex0), 32'h40);
		check_value("hex1", 32'(hex1), 32'h40);

		// untouched crop ripens and then withers
		wait_for("crop_ripe", crop_ripe, 200);
		wait_for("crop_withered", crop_withered, 200);
		check_value("crop_ripe", 32'(crop_ripe), 32'h0);

		// up has priority over left
		go_y(47);
		@(posedge clk);
		move_up   <= 1'b1;
		move_left <= 1'b1;
		for (k = 0; k < 40 && int'(pos_y) != 44; k++)
			@(negedge clk);
		check_value("pos_y", 32'(pos_y), 32'd44);
		check_value("pos_x", 32'(pos_x), 32'd50);
		@(posedge clk);
		move_left <= 1'b0;
		for (k = 0; k < 300 && int'(pos_y) != 12; k++)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_value("pos_y", 32'(pos_y), 32'd12);
		@(posedge clk);
		move_up   <= 1'b0;
		move_left <= 1'b1;
		for (k = 0; k < 300 && int'(pos_x) != 12; k++)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_value("pos_x", 32'(pos_x), 32'd12);
		@(posedge clk);
		move_left <= 1'b0;

		// down and right stop at the far bounds
		@(posedge clk);
		move_down <= 1'b1;
		for (k = 0; k < 300 && int'(pos_y) != 72; k++)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_value("pos_y", 32'(pos_y), 32'd72);
		@(posedge clk);
		move_down  <= 1'b0;
		move_right <= 1'b1;
		for (k = 0; k < 600 && int'(pos_x) != 133; k++)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_value("pos_x", 32'(pos_x), 32'd133);
		@(posedge clk);
		move_right <= 1'b0;
		go_y(12);

		// replanting a withered field gives no wheat
		go_x(50);
		if (!crop_withered)
			stop_with_failure("field was not withered on arrival");
		do_action();
		check_value("crop_ripe", 32'(crop_ripe), 32'h0);
		check_value("crop_withered", 32'(crop_withered), 32'h0);
		check_value("has_wheat", 32'(has_wheat), 32'h0);

		for (k = 1; k <= 4; k++)
			make_and_sell(k);
		check_value("hex0", 32'(hex0), 32'(expected_segments(4'h4)));

		// clear drops the wheat and keeps the score
		go_y(12);
		go_x(50);
		harvest_wheat();
		@(posedge clk);
		clear_items <= 1'b1;
		wait_for("clear_strobe", i_dut.clear_strobe, 20);
		@(posedge clk);
		clear_items <= 1'b0;
		repeat (3) @(negedge clk);
		check_value("has_wheat", 32'(has_wheat), 32'h0);
		check_value("score", 32'(score), 32'd4);
		check_value("rich", 32'(rich), 32'h1);

		$display("Regression passed");
		$finish;
	end

	// overall limit for the run
	initial
	begin
		#2000000;
		stop_with_failure("simulation ran past its time limit");
	end

endmodule
